/* reg_params.svh */
`ifndef REG_PARAMS_SVH
`define REG_PARAMS_SVH

// Word width on the host port and the native bus
`define REG_DATA_WIDTH 32

// Host address: region field on top, word index below
`define REG_ADDR_WIDTH 8
`define MEM_ADDR_WIDTH 6

// Mapped regions, the rest of the region field is unmapped
`define MEM_BANKS 2

// Cycles the bridge waits in WAIT before giving up on an acknowledge
`define REG_TIMEOUT 16

`endif

/* reg_pkg.sv */
`default_nettype none

`include "reg_params.svh"

package reg_pkg;

    // Data word on both the host port and the native bus
    typedef logic [`REG_DATA_WIDTH-1:0] reg_data_t;

    // Full host address
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Word index inside one bank
    typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // Region field, the address bits above the word index
    typedef logic [`REG_ADDR_WIDTH-`MEM_ADDR_WIDTH-1:0] bank_sel_t;

    // Bridge FSM
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT,
        DONE
    } bridge_state_t;

endpackage

`default_nettype wire

/* reg_native_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface reg_native_if;
    import reg_pkg::*;

    // Request side, driven by the master
    logic      req_vld;
    logic      wr_en;
    logic      rd_en;
    reg_addr_t addr;
    reg_data_t wr_data;

    // Response side, driven by the slave
    logic      ack_vld;
    reg_data_t rd_data;

    modport master (
        output req_vld,
        output wr_en,
        output rd_en,
        output addr,
        output wr_data,
        input  ack_vld,
        input  rd_data
    );

    modport slave (
        input  req_vld,
        input  wr_en,
        input  rd_en,
        input  addr,
        input  wr_data,
        output ack_vld,
        output rd_data
    );

endinterface

`default_nettype wire

/* ext_mem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "reg_params.svh"

module ext_mem (
    input  wire         clk,
    input  wire         reset,
    reg_native_if.slave bus
);
    import reg_pkg::*;

    localparam int MEM_ENTRIES = 1 << `MEM_ADDR_WIDTH;

    // Registered copy of the request
    logic      req_vld_ff;
    logic      wr_en_ff;
    logic      rd_en_ff;
    mem_addr_t addr_ff;
    reg_data_t wr_data_ff;

    reg_data_t mem [0:MEM_ENTRIES-1];

    logic      wr_hit;
    logic      rd_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_vld_ff <= 1'b0;
            wr_en_ff   <= 1'b0;
            rd_en_ff   <= 1'b0;
        end else begin
            req_vld_ff <= bus.req_vld;
            wr_en_ff   <= bus.wr_en;
            rd_en_ff   <= bus.rd_en;
        end
    end

    // Only the low bits of the address select a word in this bank
    always_ff @(posedge clk) begin
        addr_ff    <= bus.addr[`MEM_ADDR_WIDTH-1:0];
        wr_data_ff <= bus.wr_data;
    end

    assign wr_hit = req_vld_ff && wr_en_ff;
    assign rd_hit = req_vld_ff && rd_en_ff;

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            mem[addr_ff] <= wr_data_ff;
        end
    end

    // Read data is valid only in the ack cycle and zero otherwise
    always_ff @(posedge clk) begin
        if (rd_hit) begin
            bus.rd_data <= mem[addr_ff];
        end else begin
            bus.rd_data <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.ack_vld <= 1'b0;
        end else begin
            bus.ack_vld <= wr_hit || rd_hit;
        end
    end

    // Each request gets a single-cycle ack
    a_ack_single: assert property (@(posedge clk) disable iff (reset)
        bus.ack_vld |=> !bus.ack_vld);

    // The master picks exactly one direction per request
    a_one_enable: assert property (@(posedge clk) disable iff (reset)
        bus.req_vld |-> !(bus.wr_en && bus.rd_en));

endmodule

`default_nettype wire

/* reg_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "reg_params.svh"

module reg_decoder (
    reg_native_if.slave  up,
    reg_native_if.master banks [`MEM_BANKS]
);
    import reg_pkg::*;

    bank_sel_t              sel;
    logic [`MEM_BANKS-1:0]  hit;
    logic [`MEM_BANKS-1:0]  ack_vec;
    reg_data_t              rdata_vec [`MEM_BANKS];
    reg_data_t              rdata_merged;

    // Region field sits directly above the word index
    assign sel = up.addr[`REG_ADDR_WIDTH-1:`MEM_ADDR_WIDTH];

    genvar i;
    generate
        for (i = 0; i < `MEM_BANKS; i++) begin : g_bank
            // An unmapped region matches no bank, so hit stays all zero
            assign hit[i] = (sel == bank_sel_t'(i));

            assign banks[i].req_vld = up.req_vld && hit[i];
            assign banks[i].wr_en   = up.wr_en;
            assign banks[i].rd_en   = up.rd_en;
            assign banks[i].addr    = up.addr;
            assign banks[i].wr_data = up.wr_data;

            assign ack_vec[i]   = banks[i].ack_vld;
            assign rdata_vec[i] = banks[i].rd_data;
        end
    endgenerate

    // Only the addressed bank may answer
    always_comb begin
        rdata_merged = '0;
        for (int b = 0; b < `MEM_BANKS; b++) begin
            if (hit[b]) begin
                rdata_merged = rdata_merged | rdata_vec[b];
            end
        end
    end

    // Unmapped access gets no ack at all, the bridge times it out
    assign up.ack_vld = |(ack_vec & hit);
    assign up.rd_data = rdata_merged;

endmodule

`default_nettype wire

/* reg_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

`include "reg_params.svh"

module reg_bridge (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 host_req,
    input  wire                 host_wr,
    input  reg_pkg::reg_addr_t  host_addr,
    input  reg_pkg::reg_data_t  host_wdata,
    output logic                host_ack,
    output logic                host_err,
    output reg_pkg::reg_data_t  host_rdata,
    reg_native_if.master        bus
);
    import reg_pkg::*;

    localparam int TMO_W = $clog2(`REG_TIMEOUT + 1);
    localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(`REG_TIMEOUT);

    bridge_state_t    state;
    logic [TMO_W-1:0] tmo_cnt;
    logic             ack_seen;
    logic             timed_out;

    assign ack_seen  = (state == WAIT) && bus.ack_vld;
    assign timed_out = (state == WAIT) && !bus.ack_vld && (tmo_cnt == TMO_LAST);

    // Response is held for the whole DONE phase
    assign host_ack = (state == DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            tmo_cnt     <= '0;
            host_err    <= 1'b0;
            bus.req_vld <= 1'b0;
            bus.wr_en   <= 1'b0;
            bus.rd_en   <= 1'b0;
        end else begin
            // Request strobe and enables last a single cycle
            bus.req_vld <= 1'b0;
            bus.wr_en   <= 1'b0;
            bus.rd_en   <= 1'b0;

            case (state)
                IDLE: begin
                    tmo_cnt <= '0;
                    if (host_req) begin
                        state <= ISSUE;
                    end
                end

                ISSUE: begin
                    bus.req_vld <= 1'b1;
                    bus.wr_en   <= host_wr;
                    bus.rd_en   <= !host_wr;
                    tmo_cnt     <= '0;
                    state       <= WAIT;
                end

                WAIT: begin
                    if (ack_seen) begin
                        host_err <= 1'b0;
                        state    <= DONE;
                    end else if (timed_out) begin
                        host_err <= 1'b1;
                        state    <= DONE;
                    end else begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end

                DONE: begin
                    // Hold off until the host releases its request
                    if (!host_req) begin
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Address and write data stay put until the next transfer
    always_ff @(posedge clk) begin
        if (state == ISSUE) begin
            bus.addr    <= host_addr;
            bus.wr_data <= host_wdata;
        end
    end

    // An aborted transfer returns zero data
    always_ff @(posedge clk) begin
        if (ack_seen) begin
            host_rdata <= bus.rd_data;
        end else if (timed_out) begin
            host_rdata <= '0;
        end
    end

    a_req_pulse: assert property (@(posedge clk) disable iff (reset)
        bus.req_vld |=> !bus.req_vld);

    a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(host_ack) |-> host_req);

endmodule

`default_nettype wire

/* reg_subsys_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "reg_params.svh"

module reg_subsys_top (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 host_req,
    input  wire                 host_wr,
    input  reg_pkg::reg_addr_t  host_addr,
    input  reg_pkg::reg_data_t  host_wdata,
    output logic                host_ack,
    output logic                host_err,
    output reg_pkg::reg_data_t  host_rdata
);

    // Bridge to decoder
    reg_native_if bus_up ();

    // Decoder to each memory bank
    reg_native_if bank_bus [`MEM_BANKS] ();

    reg_bridge bridge_i (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .host_wr    (host_wr),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_err   (host_err),
        .host_rdata (host_rdata),
        .bus        (bus_up.master)
    );

    reg_decoder decoder_i (
        .up    (bus_up.slave),
        .banks (bank_bus)
    );

    ext_mem bank0_i (
        .clk   (clk),
        .reset (reset),
        .bus   (bank_bus[0].slave)
    );

    ext_mem bank1_i (
        .clk   (clk),
        .reset (reset),
        .bus   (bank_bus[1].slave)
    );

endmodule

`default_nettype wire

/* tb_reg_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

`include "reg_params.svh"

module tb_reg_subsys;
    import reg_pkg::*;

    localparam int BANK_WORDS      = 1 << `MEM_ADDR_WIDTH;
    localparam int MODEL_WORDS     = `MEM_BANKS * BANK_WORDS;
    localparam int N_RANDOM        = 200;
    // Directed transfers plus the random run
    localparam int N_XFER          = N_RANDOM + 20;
    localparam int WATCHDOG_CYCLES = N_XFER * (`REG_TIMEOUT + 10);
    // Edges from the first sampled host_req to host_ack
    localparam int LAT_MAPPED      = 4;
    localparam int LAT_UNMAPPED    = `REG_TIMEOUT + 2;

    logic      clk;
    logic      reset;
    logic      host_req;
    logic      host_wr;
    reg_addr_t host_addr;
    reg_data_t host_wdata;
    logic      host_ack;
    logic      host_err;
    reg_data_t host_rdata;

    // Reference image of both banks
    reg_data_t model [0:MODEL_WORDS-1];
    logic      written [0:MODEL_WORDS-1];

    reg_data_t exp_data_q [$];
    logic      exp_err_q [$];

    int        err_cnt;
    int        xfer_cnt;
    logic      ack_prev;
    reg_data_t cmp_data;
    logic      cmp_err;

    reg_subsys_top reg_subsys_top_i (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .host_wr    (host_wr),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_err   (host_err),
        .host_rdata (host_rdata)
    );

    always #50 clk = ~clk;

    function automatic int word_index(input reg_addr_t addr);
        bank_sel_t sel;
        sel = addr[`REG_ADDR_WIDTH-1:`MEM_ADDR_WIDTH];
        return int'(sel) * BANK_WORDS + int'(addr[`MEM_ADDR_WIDTH-1:0]);
    endfunction

    // Expected response of one transfer and the bank image update of a mapped write
    function automatic void ref_access(
        input  logic      wr,
        input  reg_addr_t addr,
        input  reg_data_t wdata,
        output reg_data_t data,
        output logic      err
    );
        bank_sel_t sel;
        sel  = addr[`REG_ADDR_WIDTH-1:`MEM_ADDR_WIDTH];
        data = '0;
        err  = 1'b0;
        if (int'(sel) >= `MEM_BANKS) begin
            // Unmapped region times out and stores nothing
            err = 1'b1;
        end else if (wr) begin
            model[word_index(addr)]   = wdata;
            written[word_index(addr)] = 1'b1;
        end else begin
            data = model[word_index(addr)];
        end
    endfunction

    // One four-phase transfer that may hold host_req past host_ack
    task automatic host_access(
        input logic      wr,
        input reg_addr_t addr,
        input reg_data_t wdata,
        input int        hold_cycles
    );
        reg_data_t exp_data;
        logic      exp_err;
        int        cycles;
        int        exp_lat;
        ref_access(wr, addr, wdata, exp_data, exp_err);
        exp_data_q.push_back(exp_data);
        exp_err_q.push_back(exp_err);
        exp_lat = exp_err ? LAT_UNMAPPED : LAT_MAPPED;
        xfer_cnt++;

        @(posedge clk);
        host_req   <= 1'b1;
        host_wr    <= wr;
        host_addr  <= addr;
        host_wdata <= wdata;

        // First edge counted is the one that samples host_req
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!host_ack);
        assert (cycles - 1 == exp_lat) else begin
            err_cnt++;
            $display("ERROR at %0t: host_ack latency expected %0d, got %0d",
                     $time, exp_lat, cycles - 1);
        end

        repeat (hold_cycles) begin
            @(negedge clk);
            assert (host_ack) else begin
                err_cnt++;
                $display("host_ack dropped at %0t while host_req was still high", $time);
            end
        end

        @(posedge clk);
        host_req <= 1'b0;
        @(negedge clk);
        assert (host_ack) else begin
            err_cnt++;
            $display("host_ack dropped at %0t before host_req low was sampled", $time);
        end
        while (host_ack) begin
            @(negedge clk);
        end
    endtask

    // Checks the response on every rising host_ack
    always @(negedge clk) begin
        if (!reset && host_ack && !ack_prev) begin
            assert (exp_data_q.size() != 0) else begin
                err_cnt++;
                $display("host_ack rose at %0t with no transfer pending", $time);
            end
            if (exp_data_q.size() != 0) begin
                cmp_data = exp_data_q.pop_front();
                cmp_err  = exp_err_q.pop_front();
                assert (host_rdata == cmp_data) else begin
                    err_cnt++;
                    $display("ERROR at %0t: host_rdata expected %h, got %h",
                             $time, cmp_data, host_rdata);
                end
                assert (host_err == cmp_err) else begin
                    err_cnt++;
                    $display("ERROR at %0t: host_err expected %b, got %b",
                             $time, cmp_err, host_err);
                end
            end
        end
        ack_prev = host_ack;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        reg_addr_t addr;
        reg_data_t data;
        logic      wr;
        bank_sel_t sel;
        void'($urandom(32'h1198));
        clk        = 1'b0;
        reset      = 1'b1;
        host_req   = 1'b0;
        host_wr    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        err_cnt    = 0;
        xfer_cnt   = 0;
        ack_prev   = 1'b0;
        for (int i = 0; i < MODEL_WORDS; i++) begin
            model[i]   = '0;
            written[i] = 1'b0;
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (host_ack == 1'b0) else begin
            err_cnt++;
            $display("ERROR at %0t: host_ack expected 0, got %b", $time, host_ack);
        end
        assert (host_err == 1'b0) else begin
            err_cnt++;
            $display("ERROR at %0t: host_err expected 0, got %b", $time, host_err);
        end

        // Write then read back in bank 0
        host_access(1'b1, 8'h05, 32'hA5A5_0001, 0);
        host_access(1'b0, 8'h05, '0, 0);

        // Same word index in bank 1 stays separate
        host_access(1'b1, 8'h45, 32'h5A5A_1111, 0);
        host_access(1'b0, 8'h05, '0, 0);
        host_access(1'b0, 8'h45, '0, 0);

        // Unmapped regions 2 and 3
        host_access(1'b0, 8'h85, '0, 0);
        host_access(1'b1, 8'hC5, 32'hDEAD_BEEF, 0);
        host_access(1'b1, 8'h85, 32'h0BAD_F00D, 0);
        host_access(1'b0, 8'hC0, '0, 0);
        host_access(1'b0, 8'h05, '0, 0);
        host_access(1'b0, 8'h45, '0, 0);

        // Held request must not start a second access
        host_access(1'b1, 8'h10, 32'h1234_5678, 5);
        host_access(1'b0, 8'h10, '0, 3);
        host_access(1'b0, 8'h10, '0, 0);

        for (int n = 0; n < N_RANDOM; n++) begin
            addr = reg_addr_t'($urandom);
            data = $urandom;
            wr   = ($urandom % 2) != 0;
            sel  = addr[`REG_ADDR_WIDTH-1:`MEM_ADDR_WIDTH];
            if (!wr && int'(sel) < `MEM_BANKS) begin
                // Reads go only to words that already hold a value
                if (!written[word_index(addr)]) begin
                    wr = 1'b1;
                end
            end
            host_access(wr, addr, data, 0);
        end

        $display("Transfers: %0d, errors: %0d", xfer_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
reg_pkg.sv
reg_native_if.sv
ext_mem.sv
reg_decoder.sv
reg_bridge.sv
reg_subsys_top.sv
tb_reg_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the register subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_reg_subsys \
    -Mdir obj_dir \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
